/* filelist.f */
verilog/s16_bus_pkg.sv
verilog/s16_cab_pkg.sv
verilog/s16_cen_gen.sv
verilog/s16_mapper.sv
verilog/s16_decoder.sv
verilog/s16_cab_io.sv
verilog/s16_bus_ctrl.sv
verilog/s16_main.sv
test/tb_s16_main.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_s16_main -f filelist.f
./obj_dir/Vtb_s16_main > sim.log 2>&1
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

/* test/tb_s16_main.sv */
`default_nettype none

module tb_s16_main
    import s16_bus_pkg::*;
    import s16_cab_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20000;  // About 60 accesses of up to 60 cycles, wide margin
    localparam int DTACK_LIMIT    = 200;
    localparam logic [7:0] CEN_NUM = 8'd29;
    localparam logic [7:0] CEN_DEN = 8'd146;

    // One-hot select masks in mem_cs_t field order
    localparam logic [7:0] SEL_NONE = 8'h00;
    localparam logic [7:0] SEL_ROM  = 8'h80;
    localparam logic [7:0] SEL_RAM  = 8'h40;
    localparam logic [7:0] SEL_VRAM = 8'h20;
    localparam logic [7:0] SEL_CHR  = 8'h10;
    localparam logic [7:0] SEL_PAL  = 8'h08;
    localparam logic [7:0] SEL_OBJ  = 8'h04;
    localparam logic [7:0] SEL_IO   = 8'h02;

    logic        clk = 1'b0;
    logic        rst;
    bus_req_t    bus;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic        cpu_cen;
    mem_cs_t     cs;
    mem_wr_t     wr;
    logic [17:0] rom_addr;
    logic [15:0] rom_data = 16'hFFFF;
    logic        rom_ok = 1'b0;
    logic [15:0] ram_data = 16'hFFFF;
    logic        ram_ok = 1'b0;
    logic [15:0] char_dout = 16'h0000;
    logic [15:0] pal_dout = 16'h0000;
    logic [15:0] obj_dout = 16'h0000;
    cab_in_t     cab;
    vid_ctrl_t   vid;

    logic [15:0] ram_mem  [4096];
    logic [15:0] vram_mem [4096];
    logic [15:0] ram_word;
    int          rom_cnt = 0;
    int          rom_dly = 0;
    int          ram_cnt = 0;
    int          ram_dly = 0;
    logic        slow_rom = 1'b0;  // Forces the longest rom_ok delay
    integer      seed;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;

    s16_main #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) DUT (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d, errors: %0d", n_checks, n_errors);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [15:0] ram_fill(input logic [11:0] a);
        return {a[3:0], a} ^ 16'h3C5A;
    endfunction

    function automatic logic [15:0] vram_fill(input logic [11:0] a);
        return {~a[3:0], a} ^ 16'h0F0F;
    endfunction

    // Expected joystick byte, source bit for output bits 7 down to 0
    function automatic logic [7:0] joy_wiring(input logic [7:0] j);
        int src [8];
        src = '{1, 0, 3, 2, 7, 5, 4, 6};
        for (int k = 0; k < 8; k++) begin
            joy_wiring[7 - k] = j[src[k]];
        end
    endfunction

    // ROM with a variable rom_ok delay
    always @(posedge clk) begin
        if (!cs.rom) begin
            rom_ok   <= 1'b0;
            rom_cnt  <= 0;
            rom_data <= ~(rom_addr[15:0] ^ 16'h5A5A);
        end else begin
            rom_cnt <= rom_cnt + 1;
            if (rom_cnt >= rom_dly) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_addr[15:0] ^ 16'h5A5A;
            end else begin
                rom_data <= ~(rom_addr[15:0] ^ 16'h5A5A);  // Wrong data until rom_ok
            end
        end
    end

    assign ram_word = cs.vram ? vram_mem[wr.addr] : ram_mem[wr.addr];

    // Work RAM and tile RAM, byte strobed
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4096; i++) begin
                ram_mem[i]  <= ram_fill(12'(i));
                vram_mem[i] <= vram_fill(12'(i));
            end
        end else begin
            if (cs.ram && !wr.uds_wn) ram_mem[wr.addr][15:8] <= wr.dout[15:8];
            if (cs.ram && !wr.lds_wn) ram_mem[wr.addr][7:0] <= wr.dout[7:0];
            if (cs.vram && !wr.uds_wn) vram_mem[wr.addr][15:8] <= wr.dout[15:8];
            if (cs.vram && !wr.lds_wn) vram_mem[wr.addr][7:0] <= wr.dout[7:0];
        end
        if (!(cs.ram || cs.vram)) begin
            ram_ok   <= 1'b0;
            ram_cnt  <= 0;
            ram_data <= ~ram_word;
        end else begin
            ram_cnt <= ram_cnt + 1;
            if (ram_cnt >= ram_dly) begin
                ram_ok   <= 1'b1;
                ram_data <= ram_word;
            end else begin
                ram_data <= ~ram_word;   // Wrong data until ram_ok
            end
        end
    end

    always @(posedge clk) begin
        char_dout <= {4'hC, bus.addr[12:1]};
        pal_dout  <= {4'hA, bus.addr[12:1]};
        obj_dout  <= {4'hB, bus.addr[12:1]};
    end

    task automatic wait_cen();
        @(posedge clk);
        while (!cpu_cen) @(posedge clk);
    endtask

    // Any CEN_DEN clocks in a row hold exactly CEN_NUM pulses
    task automatic cen_rate();
        int pulses;
        pulses = 0;
        repeat (int'(CEN_DEN)) begin
            @(posedge clk);
            if (cpu_cen) pulses++;
        end
        n_checks++;
        if (pulses != int'(CEN_NUM)) begin
            n_errors++;
            $display("mismatch at %0t: %0d cpu_cen pulses in %0d clocks, expected %0d",
                     $time, pulses, CEN_DEN, CEN_NUM);
        end
    endtask

    // One 68000 bus cycle, returns read data and every select seen high
    task automatic bus_access(input logic [23:0] a, input logic rnw, input logic [15:0] wdata,
                              input logic uds_n, input logic lds_n,
                              output logic [15:0] rdata, output logic [7:0] seen);
        int   waited;
        logic acked;
        seen    = SEL_NONE;
        waited  = 0;
        rom_dly = slow_rom ? 7 : ($random(seed) & 7);
        ram_dly = $random(seed) & 7;
        wait_cen();
        bus <= '{addr: a[23:1], as_n: 1'b0, uds_n: uds_n, lds_n: lds_n, rnw: rnw, dout: wdata};
        @(posedge clk);
        while (dtack_n && waited < DTACK_LIMIT) begin
            seen |= cs;
            waited++;
            @(posedge clk);
        end
        seen |= cs;
        rdata = cpu_din;
        acked = !dtack_n;
        if (dtack_n) begin
            n_errors++;
            $display("no dtack_n within %0d cycles for the access at %h", DTACK_LIMIT, a);
        end
        wait_cen();
        bus.as_n  <= 1'b1;
        bus.uds_n <= 1'b1;
        bus.lds_n <= 1'b1;
        bus.rnw   <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (!dtack_n && waited < DTACK_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (acked) begin
            n_checks++;
            if (!dtack_n) begin
                n_errors++;
                $display("dtack_n stayed low after as_n rose for the access at %h", a);
            end else if (waited != 1) begin
                n_errors++;
                $display("mismatch at %0t: dtack_n rose %0d clocks after as_n, expected 1",
                         $time, waited);
            end
        end
    endtask

    task automatic bus_write(input logic [23:0] a, input logic [15:0] d,
                             input logic uds_n, input logic lds_n);
        logic [15:0] unused_d;
        logic [7:0]  unused_cs;
        bus_access(a, 1'b0, d, uds_n, lds_n, unused_d, unused_cs);
    endtask

    task automatic check_read(input logic [23:0] a, input logic [15:0] exp_d,
                              input logic [7:0] exp_cs);
        logic [15:0] d;
        logic [7:0]  seen;
        bus_access(a, 1'b1, 16'h0000, 1'b0, 1'b0, d, seen);
        n_checks++;
        if (d !== exp_d) begin
            n_errors++;
            $display("mismatch at %0t: read %h gave %h, expected %h", $time, a, d, exp_d);
        end
        if (seen !== exp_cs) begin
            n_errors++;
            $display("mismatch at %0t: read %h raised selects %b, expected %b",
                     $time, a, seen, exp_cs);
        end
    endtask

    task automatic check_vid(input logic flip, input logic ven, input logic [5:0] bank);
        n_checks++;
        if (vid.flip !== flip || vid.video_en !== ven || vid.tile_bank !== bank) begin
            n_errors++;
            $display("mismatch at %0t: vid %b/%b/%h, expected %b/%b/%h", $time,
                     vid.flip, vid.video_en, vid.tile_bank, flip, ven, bank);
        end
    endtask

    // Base byte, then enable and size code
    task automatic map_region(input logic [2:0] r, input logic [7:0] base,
                              input logic en, input logic [1:0] size);
        bus_write({19'h7FFFF, r, 2'b00}, {8'h00, base}, 1'b1, 1'b0);
        bus_write({19'h7FFFF, r, 2'b10}, {13'h0000, en, size}, 1'b1, 1'b0);
    endtask

    task automatic boot_rom_reads();
        check_vid(1'b0, 1'b1, 6'd0);
        check_read(24'h000000, 16'h0000 ^ 16'h5A5A, SEL_ROM);
        check_read(24'h012346, 16'h91A3 ^ 16'h5A5A, SEL_ROM);
        check_read(24'h07FFFE, 16'hFFFF ^ 16'h5A5A, SEL_ROM);
    endtask

    task automatic mapper_routing();
        check_read(24'hFF0010, 16'hFFFF, SEL_NONE);   // RAM still disabled
        map_region(3'd1, 8'h08, 1'b1, 2'd3);
        map_region(3'd2, 8'h10, 1'b1, 2'd0);
        map_region(3'd3, 8'hFF, 1'b1, 2'd0);
        map_region(3'd4, 8'h44, 1'b1, 2'd0);
        map_region(3'd5, 8'h40, 1'b1, 2'd1);
        map_region(3'd6, 8'h44, 1'b1, 2'd0);           // Overlaps region 4
        map_region(3'd7, 8'hC4, 1'b0, 2'd0);
        check_read(24'h080010, 16'h0008 ^ 16'h5A5A, SEL_ROM);
        check_read(24'hFF0010, ram_fill(12'h008), SEL_RAM);
        check_read(24'h400020, vram_fill(12'h010), SEL_VRAM);
        check_read(24'h410040, 16'hC020, SEL_CHR);
        check_read(24'h440008, 16'hB004, SEL_OBJ);     // Region 4 wins
        map_region(3'd6, 8'h84, 1'b1, 2'd0);
        check_read(24'h840006, 16'hA003, SEL_PAL);
        check_read(24'hC40000, 16'hFFFF, SEL_NONE);
        map_region(3'd7, 8'hC4, 1'b1, 2'd0);
    endtask

    task automatic cabinet_inputs();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [7:0]  sys_byte;
        for (int round = 0; round < 2; round++) begin
            r_hi = $random(seed);
            r_lo = $random(seed);
            @(posedge clk);
            cab <= {r_hi, r_lo[7:0]};
            @(posedge clk);
            sys_byte = {1'b1, 1'b1, cab.start[1], cab.start[0], cab.service, cab.dip_test,
                        cab.coin[1], cab.coin[0]};
            check_read(24'hC41000, {8'hFF, sys_byte}, SEL_IO);
            check_read(24'hC41002, {8'hFF, joy_wiring(cab.joy1)}, SEL_IO);
            check_read(24'hC41004, 16'hFFFF, SEL_IO);
            check_read(24'hC41006, {8'hFF, joy_wiring(cab.joy2)}, SEL_IO);
            check_read(24'hC42000, {8'hFF, cab.dipsw_b}, SEL_IO);
            check_read(24'hC42002, {8'hFF, cab.dipsw_a}, SEL_IO);
            check_read(24'hC43000, 16'hFFFF, SEL_IO);
        end
    endtask

    task automatic video_control();
        bus_write(24'hC40000, 16'h0040, 1'b1, 1'b0);
        check_vid(1'b1, 1'b0, 6'd0);
        bus_write(24'hC40000, 16'h0020, 1'b1, 1'b0);
        check_vid(1'b0, 1'b1, 6'd0);
        bus_write(24'h100002, 16'h0005, 1'b1, 1'b0);   // Upper half
        check_vid(1'b0, 1'b1, 6'b101_000);
        bus_write(24'h100000, 16'h0003, 1'b1, 1'b0);
        check_vid(1'b0, 1'b1, 6'b101_011);
    endtask

    task automatic ram_byte_writes();
        bus_write(24'hFF0100, 16'h1234, 1'b0, 1'b0);
        check_read(24'hFF0100, 16'h1234, SEL_RAM);
        bus_write(24'hFF0100, 16'hAB55, 1'b0, 1'b1);
        check_read(24'hFF0100, 16'hAB34, SEL_RAM);
        bus_write(24'hFF0100, 16'h66CD, 1'b1, 1'b0);
        check_read(24'hFF0100, 16'hABCD, SEL_RAM);
    endtask

    task automatic unmapped_and_slow_rom();
        check_read(24'hC80000, 16'hFFFF, SEL_NONE);
        check_read(24'hFFFFE0, 16'hFFFF, SEL_NONE);   // Mapper window
        slow_rom = 1'b1;
        check_read(24'h002468, 16'h1234 ^ 16'h5A5A, SEL_ROM);
        slow_rom = 1'b0;
    endtask

    initial begin
        seed = 32'h1de892f2;
        rst <= 1'b1;
        bus <= '{addr: '0, as_n: 1'b1, uds_n: 1'b1, lds_n: 1'b1, rnw: 1'b1, dout: 16'h0000};
        cab <= '1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        cen_rate();
        boot_rom_reads();
        mapper_routing();
        cabinet_inputs();
        video_control();
        ram_byte_writes();
        unmapped_and_slow_rom();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/s16_bus_ctrl.sv */
`default_nettype none

module s16_bus_ctrl
    import s16_bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          cpu_cen,
    input  wire          as_n,
    input  wire mem_cs_t cs,
    input  wire          map_cs,
    input  wire          rom_ok,
    input  wire          ram_ok,
    input  wire [15:0]   rom_data,
    input  wire [15:0]   ram_data,
    input  wire [15:0]   char_dout,
    input  wire [15:0]   pal_dout,
    input  wire [15:0]   obj_dout,
    input  wire [7:0]    cab_dout,
    output logic [15:0]  cpu_din,
    output logic         dtack_n
);

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT,
        BUS_ACK
    } bus_state_e;

    bus_state_e  state;
    logic        as_q;      // Lets selects and cab_dout settle first
    logic        busy;
    logic [15:0] rd_data;

    // Only the SDRAM-backed memories can stall the CPU
    assign busy = (cs.rom & ~rom_ok) | ((cs.ram | cs.vram) & ~ram_ok);

    always_comb begin
        if (cs.ram || cs.vram) begin
            rd_data = ram_data;
        end else if (cs.rom) begin
            rd_data = rom_data;
        end else if (cs.chr) begin
            rd_data = char_dout;
        end else if (cs.pal) begin
            rd_data = pal_dout;
        end else if (cs.obj) begin
            rd_data = obj_dout;
        end else if (cs.io) begin
            rd_data = {8'hFF, cab_dout};
        end else if (map_cs) begin
            rd_data = 16'hFFFF;     // Mapper registers are write only
        end else begin
            rd_data = 16'hFFFF;     // Unmapped, acknowledged anyway
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= BUS_IDLE;
            as_q    <= 1'b1;
            dtack_n <= 1'b1;
            cpu_din <= 16'hFFFF;
        end else begin
            as_q <= as_n;
            case (state)
                BUS_IDLE: if (!as_q) state <= BUS_WAIT;
                BUS_WAIT: begin
                    if (as_n) begin
                        state <= BUS_IDLE;
                    end else if (cpu_cen && !busy) begin
                        state   <= BUS_ACK;
                        dtack_n <= 1'b0;
                        cpu_din <= rd_data;   // Held until the next access
                    end
                end
                BUS_ACK: begin
                    if (as_n) begin
                        state   <= BUS_IDLE;
                        dtack_n <= 1'b1;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/s16_bus_pkg.sv */
`default_nettype none

package s16_bus_pkg;

    // Mapper regions, the index into the one-hot active vector
    typedef enum logic [2:0] {
        REG_ROM0 = 3'd0,
        REG_ROM1 = 3'd1,
        REG_ROM2 = 3'd2,  // Also the tile bank latch on writes
        REG_RAM  = 3'd3,
        REG_ORAM = 3'd4,
        REG_VRAM = 3'd5,  // A16 splits tile RAM and text RAM
        REG_PAL  = 3'd6,
        REG_IO   = 3'd7
    } region_e;

    // 68000 bus as seen from the CPU side
    typedef struct packed {
        logic [23:1] addr;
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [15:0] dout;    // Write data
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic pal;
        logic obj;
        logic io;
        logic tbank;
    } mem_cs_t;

    // Write side toward the video and work memories
    typedef struct packed {
        logic [12:1] addr;
        logic [15:0] dout;
        logic        uds_wn;
        logic        lds_wn;
    } mem_wr_t;

endpackage

`default_nettype wire

/* verilog/s16_cab_io.sv */
`default_nettype none

module s16_cab_io
    import s16_bus_pkg::*;
    import s16_cab_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire mem_cs_t cs,
    input  wire [23:1]   addr,
    input  wire mem_wr_t wr,
    input  wire cab_in_t cab,
    output logic [7:0]   cab_dout,
    output vid_ctrl_t    vid
);

    io_page_e   page;
    logic [7:0] sort1;
    logic [7:0] sort2;

    // Harness wiring puts the joystick bits in this order
    function automatic logic [7:0] sort_joy(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    assign page  = io_page_e'(addr[13:12]);
    assign sort1 = sort_joy(cab.joy1);
    assign sort2 = sort_joy(cab.joy2);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cab_dout     <= 8'hFF;
            vid.flip     <= 1'b0;
            vid.video_en <= 1'b1;
        end else begin
            cab_dout <= 8'hFF;   // Idle bus reads high
            if (cs.io) begin
                case (page)
                    IO_CTRL: begin
                        if (!wr.lds_wn) begin
                            vid.flip     <= wr.dout[6];
                            vid.video_en <= wr.dout[5];
                        end
                    end
                    IO_INPUTS: begin
                        case (addr[2:1])
                            2'd0: cab_dout <= {2'b11, cab.start, cab.service,
                                               cab.dip_test, cab.coin};
                            2'd1: cab_dout <= sort1;
                            2'd3: cab_dout <= sort2;
                            default: cab_dout <= 8'hFF;
                        endcase
                    end
                    IO_DIPS: cab_dout <= addr[1] ? cab.dipsw_a : cab.dipsw_b;
                    IO_NONE: cab_dout <= 8'hFF;
                    default: cab_dout <= 8'hFF;
                endcase
            end
        end
    end

    // Tile bank halves picked by A1
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vid.tile_bank <= 6'd0;
        end else if (cs.tbank && !wr.lds_wn) begin
            if (addr[1]) begin
                vid.tile_bank[5:3] <= wr.dout[2:0];
            end else begin
                vid.tile_bank[2:0] <= wr.dout[2:0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/s16_cab_pkg.sv */
`default_nettype none

package s16_cab_pkg;

    // Raw cabinet inputs, active low as on the harness
    typedef struct packed {
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
        logic [1:0] spare;
    } cab_in_t;

    typedef struct packed {
        logic       flip;
        logic       video_en;
        logic [5:0] tile_bank;
    } vid_ctrl_t;

    // I/O page, taken from A13..A12
    typedef enum logic [1:0] {
        IO_CTRL   = 2'd0,
        IO_INPUTS = 2'd1,
        IO_DIPS   = 2'd2,
        IO_NONE   = 2'd3
    } io_page_e;

endpackage

`default_nettype wire

/* verilog/s16_cen_gen.sv */
`default_nettype none

module s16_cen_gen #(
    parameter logic [7:0] CEN_NUM = 8'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  wire  clk,
    input  wire  rst,
    output logic cpu_cen,
    output logic cpu_cenb
);

    localparam logic [8:0] NUM  = {1'b0, CEN_NUM};
    localparam logic [8:0] DEN  = {1'b0, CEN_DEN};
    localparam logic [8:0] HALF = DEN >> 1;

    logic [8:0] acc_a;     // Phase of cpu_cen
    logic [8:0] acc_b;     // Same step, offset by half a period
    logic [8:0] sum_a;
    logic [8:0] sum_b;

    assign sum_a = acc_a + NUM;
    assign sum_b = acc_b + NUM;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc_a    <= 9'd0;
            acc_b    <= HALF;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= sum_a >= DEN;
            cpu_cenb <= sum_b >= DEN;
            acc_a    <= (sum_a >= DEN) ? sum_a - DEN : sum_a;
            acc_b    <= (sum_b >= DEN) ? sum_b - DEN : sum_b;
        end
    end

endmodule

`default_nettype wire

/* verilog/s16_decoder.sv */
`default_nettype none

module s16_decoder
    import s16_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire bus_req_t bus,
    input  wire [7:0]     active,
    input  wire           map_hit,
    output mem_cs_t       cs,
    output logic          map_cs,
    output logic [17:0]   rom_addr,
    output mem_wr_t       wr
);

    mem_cs_t cs_next;
    logic    busn;      // Address strobe with at least one data strobe

    assign busn = bus.as_n | (bus.uds_n & bus.lds_n);

    always_comb begin
        cs_next       = '0;
        cs_next.rom   = |active[REG_ROM2:REG_ROM0] && bus.rnw;
        cs_next.ram   = !busn && active[REG_RAM];
        cs_next.obj   = active[REG_ORAM];
        cs_next.vram  = !busn && active[REG_VRAM] && !bus.addr[16];
        cs_next.chr   = active[REG_VRAM] && bus.addr[16];
        cs_next.pal   = active[REG_PAL];
        cs_next.io    = active[REG_IO];
        cs_next.tbank = active[REG_ROM2] && !bus.rnw;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cs     <= '0;
            map_cs <= 1'b0;
        end else if (!bus.as_n) begin
            cs     <= cs_next;
            map_cs <= map_hit;
        end else begin
            cs     <= '0;     // Drop as soon as the CPU ends the cycle
            map_cs <= 1'b0;
        end
    end

    // 512 kB of program ROM
    assign rom_addr = {active[REG_ROM1], bus.addr[17:1]};

    assign wr.addr   = bus.addr[12:1];
    assign wr.dout   = bus.dout;
    assign wr.uds_wn = bus.rnw | bus.uds_n;
    assign wr.lds_wn = bus.rnw | bus.lds_n;

endmodule

`default_nettype wire

/* verilog/s16_main.sv */
`default_nettype none

module s16_main
    import s16_bus_pkg::*;
    import s16_cab_pkg::*;
#(
    parameter logic [7:0] CEN_NUM = 8'd29,
    parameter logic [7:0] CEN_DEN = 8'd146
) (
    input  wire           clk,
    input  wire           rst,
    input  wire bus_req_t bus,
    output logic [15:0]   cpu_din,
    output logic          dtack_n,
    output logic          cpu_cen,
    output mem_cs_t       cs,
    output mem_wr_t       wr,
    output logic [17:0]   rom_addr,
    input  wire [15:0]    rom_data,
    input  wire           rom_ok,
    input  wire [15:0]    ram_data,
    input  wire           ram_ok,
    input  wire [15:0]    char_dout,
    input  wire [15:0]    pal_dout,
    input  wire [15:0]    obj_dout,
    input  wire cab_in_t  cab,
    output vid_ctrl_t     vid
);

    logic [7:0] active;
    logic       map_hit;
    logic       map_cs;
    logic [7:0] cab_dout;

    // cpu_cenb is for a CPU core, not modelled here
    s16_cen_gen #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_cen (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb ()
    );

    s16_mapper u_mapper (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .active  (active),
        .map_hit (map_hit)
    );

    s16_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .active   (active),
        .map_hit  (map_hit),
        .cs       (cs),
        .map_cs   (map_cs),
        .rom_addr (rom_addr),
        .wr       (wr)
    );

    s16_cab_io u_cab (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .addr     (bus.addr),
        .wr       (wr),
        .cab      (cab),
        .cab_dout (cab_dout),
        .vid      (vid)
    );

    s16_bus_ctrl u_bus (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .as_n      (bus.as_n),
        .cs        (cs),
        .map_cs    (map_cs),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din),
        .dtack_n   (dtack_n)
    );

endmodule

`default_nettype wire

/* verilog/s16_mapper.sv */
`default_nettype none

module s16_mapper
    import s16_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire bus_req_t bus,
    output logic [7:0]  active,
    output logic        map_hit
);

    logic [7:0] base [8];   // Compared with A23..A16
    logic [7:0] en;
    logic [1:0] size [8];   // 2^size blocks of 64 kB
    logic [7:0] match;
    logic       reg_wr;
    region_e    sel;

    function automatic logic region_hit(input logic [7:0] a_hi, input logic [7:0] b,
                                        input logic [1:0] s);
        logic [7:0] mask;
        mask = 8'hFF << s;
        return ((a_hi ^ b) & mask) == 8'h00;
    endfunction

    // Register window at FFFFE0..FFFFFF
    assign map_hit = &bus.addr[23:5];
    assign reg_wr  = map_hit && !bus.as_n && !bus.rnw && !bus.lds_n;
    assign sel     = region_e'(bus.addr[4:2]);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                base[i] <= 8'h00;
                en[i]   <= (i == 0);                  // Boot ROM only
                size[i] <= (i == 0) ? 2'd3 : 2'd0;
            end
        end else if (reg_wr) begin
            if (bus.addr[1]) begin
                en[sel]   <= bus.dout[2];
                size[sel] <= bus.dout[1:0];
            end else begin
                base[sel] <= bus.dout[7:0];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            match[i] = en[i] && region_hit(bus.addr[23:16], base[i], size[i]);
        end
    end

    // Lowest index wins, the window masks every region
    assign active = map_hit ? 8'h00 : (match & (~match + 8'd1));

endmodule

`default_nettype wire
